// File: include/reg_manage_defines.svh
`ifndef REG_MANAGE_DEFINES_SVH
`define REG_MANAGE_DEFINES_SVH

// instructions handled per cycle
`define INST_W_PARA     2
// write-back ports from the execute side
`define WRITE_PARA      2

`define LEN_WORD        32
`define LEN_PREG_ADDR   5
// one bit per speculation level
`define LEN_CONTEXT     4

// fixed link register number
`define LR_ADDR         1

// derived sizes
`define NUM_PREG        (1 << `LEN_PREG_ADDR)
// rs1 and rs2 for every slot
`define READ_PORTS      (2 * `INST_W_PARA)

`endif

// File: src/reg_types_pkg.sv
`include "reg_manage_defines.svh"

package reg_types_pkg;

    // data word as held in the register file
    typedef logic [`LEN_WORD-1:0] word_t;

    // register number, virtual and physical are the same here
    typedef logic [`LEN_PREG_ADDR-1:0] preg_addr_t;

    // speculation context of a pending write
    // all zero means the register has no outstanding write
    typedef logic [`LEN_CONTEXT-1:0] context_t;

endpackage

// File: src/inst_pkg.sv
package inst_pkg;

    // one decoded instruction as presented by decode
    typedef struct packed {
        logic                      rs1_order;
        reg_types_pkg::preg_addr_t rs1;
        logic                      rs2_order;
        reg_types_pkg::preg_addr_t rs2;
        logic                      rd_order;
        reg_types_pkg::preg_addr_t rd;
        // context the instruction was issued under
        reg_types_pkg::context_t   ctx;
    } inst_vreg_t;

    // per-slot answer back to decode
    typedef struct packed {
        logic                      rs1_ready;
        reg_types_pkg::word_t      rs1_data;
        logic                      rs2_ready;
        reg_types_pkg::word_t      rs2_data;
        logic                      rd_ready;
        reg_types_pkg::preg_addr_t rd;
        // slot belongs to a cancelled context
        logic                      hazard;
    } inst_d_r_t;

    // one write-back port from execute
    typedef struct packed {
        logic                      order;
        reg_types_pkg::preg_addr_t rd;
        reg_types_pkg::word_t      data;
    } write_d_r_t;

endpackage

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "reg_manage_defines.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  reg_types_pkg::preg_addr_t rd_addr [`READ_PORTS],
    output reg_types_pkg::word_t      rd_data [`READ_PORTS],
    input  inst_pkg::write_d_r_t      wb [`WRITE_PARA],
    output reg_types_pkg::word_t      lr_data
);

    import reg_types_pkg::*;

    localparam preg_addr_t LR = preg_addr_t'(`LR_ADDR);

    word_t regs [`NUM_PREG];

    // storage value, overridden by a same-cycle write-back
    function automatic word_t bypass_read(input preg_addr_t addr);
        word_t value;
        value = regs[addr];
        for (int w = 0; w < `WRITE_PARA; w++) begin
            if (wb[w].order && wb[w].rd == addr) begin
                value = wb[w].data;
            end
        end
        // register zero is hardwired
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        for (int p = 0; p < `READ_PORTS; p++) begin
            rd_data[p] = bypass_read(rd_addr[p]);
        end
        lr_data = bypass_read(LR);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_PREG; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `WRITE_PARA; w++) begin
                if (wb[w].order && wb[w].rd != '0) begin
                    regs[wb[w].rd] <= wb[w].data;
                end
            end
        end
    end

    // execute must never retire two results into one register together
    for (genvar i = 0; i < `WRITE_PARA; i++) begin : g_wb_pair
        for (genvar j = i + 1; j < `WRITE_PARA; j++) begin : g_wb_other
            a_wb_unique: assert property (
                @(posedge clk) disable iff (!rst_n)
                (wb[i].order && wb[j].order) |-> (wb[i].rd != wb[j].rd || wb[i].rd == '0)
            ) else $error("write-back ports %0d and %0d both target r%0d", i, j, wb[i].rd);
        end
    end

endmodule

// File: src/pending_table.sv
`timescale 1ns/1ps
`include "reg_manage_defines.svh"

module pending_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  inst_pkg::write_d_r_t      wb [`WRITE_PARA],
    input  logic                      branch_hazard,
    input  reg_types_pkg::context_t   hazard_ctx,
    output reg_types_pkg::context_t   eff_tags [`NUM_PREG],
    input  logic [`INST_W_PARA-1:0]   claim_valid,
    input  reg_types_pkg::preg_addr_t claim_rd [`INST_W_PARA],
    input  reg_types_pkg::context_t   claim_ctx [`INST_W_PARA]
);

    import reg_types_pkg::*;

    context_t tags [`NUM_PREG];
    context_t next_tags [`NUM_PREG];

    // registers retired by a write-back this cycle
    logic [`NUM_PREG-1:0] wb_hit;

    always_comb begin
        wb_hit = '0;
        for (int w = 0; w < `WRITE_PARA; w++) begin
            if (wb[w].order) begin
                wb_hit[wb[w].rd] = 1'b1;
            end
        end
    end

    // clear on write-back or on a flush of an overlapping context
    always_comb begin
        for (int r = 0; r < `NUM_PREG; r++) begin
            if (r == 0 || wb_hit[r]) begin
                eff_tags[r] = '0;
            end else if (branch_hazard && (|(tags[r] & hazard_ctx))) begin
                eff_tags[r] = '0;
            end else begin
                eff_tags[r] = tags[r];
            end
        end
    end

    // claims in slot order, so the youngest writer owns the register
    always_comb begin
        next_tags = eff_tags;
        for (int s = 0; s < `INST_W_PARA; s++) begin
            if (claim_valid[s] && claim_rd[s] != '0) begin
                next_tags[claim_rd[s]] = claim_ctx[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_PREG; r++) begin
                tags[r] <= '0;
            end
        end else begin
            tags <= next_tags;
        end
    end

    // a zero tag would mark the claimed register free again
    for (genvar s = 0; s < `INST_W_PARA; s++) begin : g_claim_chk
        a_claim_ctx: assert property (
            @(posedge clk) disable iff (!rst_n)
            claim_valid[s] |-> claim_ctx[s] != '0
        ) else $error("slot %0d claims r%0d with a zero context", s, claim_rd[s]);
    end

endmodule

// File: src/reg_manage.sv
`timescale 1ns/1ps
`include "reg_manage_defines.svh"

module reg_manage (
    input  inst_pkg::inst_vreg_t      req [`INST_W_PARA],
    input  reg_types_pkg::word_t      rs_data [`READ_PORTS],
    input  reg_types_pkg::context_t   eff_tags [`NUM_PREG],
    input  logic                      branch_hazard,
    input  reg_types_pkg::context_t   hazard_ctx,
    output inst_pkg::inst_d_r_t       rsp [`INST_W_PARA],
    output reg_types_pkg::preg_addr_t rs_addr [`READ_PORTS],
    output logic [`INST_W_PARA-1:0]   claim_valid,
    output reg_types_pkg::preg_addr_t claim_rd [`INST_W_PARA],
    output reg_types_pkg::context_t   claim_ctx [`INST_W_PARA]
);

    import reg_types_pkg::*;
    import inst_pkg::*;

    // tag view seen by each slot
    // slot s sees the claims of all older slots in the bundle
    context_t view [`INST_W_PARA][`NUM_PREG];

    assign view[0] = eff_tags;

    for (genvar s = 0; s < `INST_W_PARA; s++) begin : g_slot
        inst_vreg_t slot;
        logic       slot_hazard;
        logic       rs1_ready;
        logic       rs2_ready;
        logic       rd_ready;

        assign slot = req[s];

        // instruction issued under a context being cancelled
        assign slot_hazard = branch_hazard && (|(slot.ctx & hazard_ctx));

        assign rs1_ready = slot.rs1_order && view[s][slot.rs1] == '0 && !slot_hazard;
        assign rs2_ready = slot.rs2_order && view[s][slot.rs2] == '0 && !slot_hazard;
        // WAW also stalls, the older write must land first
        assign rd_ready  = slot.rd_order && view[s][slot.rd] == '0 && !slot_hazard;

        assign rs_addr[2*s]     = slot.rs1;
        assign rs_addr[2*s + 1] = slot.rs2;

        assign rsp[s] = '{
            rs1_ready: rs1_ready,
            rs1_data:  rs_data[2*s],
            rs2_ready: rs2_ready,
            rs2_data:  rs_data[2*s + 1],
            rd_ready:  rd_ready,
            rd:        slot.rd,
            hazard:    slot_hazard
        };

        // an accepted destination is reserved under the slot's context
        assign claim_valid[s] = rd_ready;
        assign claim_rd[s]    = slot.rd;
        assign claim_ctx[s]   = slot.ctx;

        // pass the updated view on to the next slot
        if (s < `INST_W_PARA - 1) begin : g_chain
            for (genvar r = 0; r < `NUM_PREG; r++) begin : g_reg
                if (r == 0) begin : g_zero
                    assign view[s+1][r] = '0;
                end else begin : g_upd
                    assign view[s+1][r] =
                        (rd_ready && slot.rd == preg_addr_t'(r)) ? slot.ctx : view[s][r];
                end
            end
        end

        // an older claim in the bundle keeps younger writers off that register
        for (genvar t = s + 1; t < `INST_W_PARA; t++) begin : g_claim_once
            always_comb begin
                a_claim_once: assert final (
                    !(claim_valid[s] && claim_valid[t] && claim_rd[s] == claim_rd[t]
                      && claim_rd[s] != '0 && claim_ctx[s] != '0)
                ) else $error("slots %0d and %0d both claim r%0d", s, t, claim_rd[s]);
            end
        end
    end

endmodule

// File: src/reg_stage.sv
`timescale 1ns/1ps
`include "reg_manage_defines.svh"

module reg_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  inst_pkg::inst_vreg_t    req [`INST_W_PARA],
    input  inst_pkg::write_d_r_t    wb [`WRITE_PARA],
    input  logic                    branch_hazard,
    input  reg_types_pkg::context_t hazard_ctx,
    output inst_pkg::inst_d_r_t     rsp [`INST_W_PARA],
    output reg_types_pkg::word_t    lr_data
);

    import reg_types_pkg::*;

    preg_addr_t              rs_addr [`READ_PORTS];
    word_t                   rs_data [`READ_PORTS];
    context_t                eff_tags [`NUM_PREG];
    logic [`INST_W_PARA-1:0] claim_valid;
    preg_addr_t              claim_rd [`INST_W_PARA];
    context_t                claim_ctx [`INST_W_PARA];

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rs_addr),
        .rd_data (rs_data),
        .wb      (wb),
        .lr_data (lr_data)
    );

    pending_table pending_table_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb            (wb),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .eff_tags      (eff_tags),
        .claim_valid   (claim_valid),
        .claim_rd      (claim_rd),
        .claim_ctx     (claim_ctx)
    );

    reg_manage reg_manage_i (
        .req           (req),
        .rs_data       (rs_data),
        .eff_tags      (eff_tags),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .rsp           (rsp),
        .rs_addr       (rs_addr),
        .claim_valid   (claim_valid),
        .claim_rd      (claim_rd),
        .claim_ctx     (claim_ctx)
    );

endmodule

// File: tests/tb_reg_stage.sv
`timescale 1ns/1ps
`include "reg_manage_defines.svh"

module tb_reg_stage;

    import reg_types_pkg::*;
    import inst_pkg::*;

    logic       clk;
    logic       rst_n;
    inst_vreg_t req [`INST_W_PARA];
    write_d_r_t wb [`WRITE_PARA];
    logic       branch_hazard;
    context_t   hazard_ctx;
    inst_d_r_t  rsp [`INST_W_PARA];
    word_t      lr_data;

    int checks;
    int errors;

    reg_stage reg_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .wb            (wb),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .rsp           (rsp),
        .lr_data       (lr_data)
    );

    always #5 clk = ~clk;

    task automatic report_and_finish();
        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic quiet_inputs();
        for (int s = 0; s < `INST_W_PARA; s++) begin
            req[s] = '0;
        end
        for (int w = 0; w < `WRITE_PARA; w++) begin
            wb[w] = '0;
        end
        branch_hazard = 1'b0;
        hazard_ctx    = '0;
    endtask

    task automatic set_slot(input int s, input logic rs1_on, input preg_addr_t rs1,
                            input logic rs2_on, input preg_addr_t rs2,
                            input logic rd_on, input preg_addr_t rd, input context_t ctx);
        req[s] = '{
            rs1_order: rs1_on,
            rs1:       rs1,
            rs2_order: rs2_on,
            rs2:       rs2,
            rd_order:  rd_on,
            rd:        rd,
            ctx:       ctx
        };
    endtask

    task automatic set_wb(input int p, input preg_addr_t rd, input word_t data);
        wb[p] = '{order: 1'b1, rd: rd, data: data};
    endtask

    // new cycle starts on the falling edge with all inputs idle
    task automatic next_cycle();
        @(negedge clk);
        quiet_inputs();
    endtask

    // let the combinational response settle before sampling
    task automatic settle();
        #2;
    endtask

    task automatic write_then_read();
        word_t w0;
        word_t w1;
        word_t w2;
        w0 = $urandom();
        w1 = $urandom();
        w2 = $urandom();
        next_cycle();
        settle();
        // idle after reset, nothing requested
        check("idle rs1 ready", 0, word_t'(rsp[0].rs1_ready));
        check("idle rd ready", 0, word_t'(rsp[1].rd_ready));
        set_wb(0, 5'd2, w0);
        set_wb(1, 5'd3, w1);
        next_cycle();
        set_wb(0, 5'd4, w2);
        // r0 must drop this write
        set_wb(1, 5'd0, w0);
        next_cycle();
        set_slot(0, 1'b1, 5'd2, 1'b1, 5'd3, 1'b0, 5'd0, 4'b0001);
        set_slot(1, 1'b1, 5'd4, 1'b1, 5'd0, 1'b0, 5'd0, 4'b0001);
        settle();
        check("write_read r2 ready", 1, word_t'(rsp[0].rs1_ready));
        check("write_read r2 data", w0, rsp[0].rs1_data);
        check("write_read r3 ready", 1, word_t'(rsp[0].rs2_ready));
        check("write_read r3 data", w1, rsp[0].rs2_data);
        check("write_read r4 ready", 1, word_t'(rsp[1].rs1_ready));
        check("write_read r4 data", w2, rsp[1].rs1_data);
        check("write_read r0 ready", 1, word_t'(rsp[1].rs2_ready));
        check("write_read r0 data", 0, rsp[1].rs2_data);
    endtask

    task automatic bypass_same_cycle();
        word_t w;
        w = $urandom();
        next_cycle();
        set_wb(1, 5'd10, w);
        set_slot(0, 1'b1, 5'd10, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001);
        settle();
        check("bypass ready", 1, word_t'(rsp[0].rs1_ready));
        check("bypass data", w, rsp[0].rs1_data);
    endtask

    task automatic raw_stall();
        word_t w;
        w = $urandom();
        next_cycle();
        set_slot(0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd5, 4'b0001);
        settle();
        check("raw claim rd ready", 1, word_t'(rsp[0].rd_ready));
        next_cycle();
        set_slot(0, 1'b1, 5'd5, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001);
        settle();
        check("raw stall cycle 1", 0, word_t'(rsp[0].rs1_ready));
        next_cycle();
        set_slot(0, 1'b1, 5'd5, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001);
        settle();
        check("raw stall cycle 2", 0, word_t'(rsp[0].rs1_ready));
        // write-back clears the reservation in the same cycle
        next_cycle();
        set_slot(0, 1'b1, 5'd5, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001);
        set_wb(0, 5'd5, w);
        settle();
        check("raw release ready", 1, word_t'(rsp[0].rs1_ready));
        check("raw release data", w, rsp[0].rs1_data);
    endtask

    task automatic chain_in_bundle();
        next_cycle();
        set_slot(0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd7, 4'b0001);
        set_slot(1, 1'b1, 5'd7, 1'b0, 5'd0, 1'b1, 5'd7, 4'b0001);
        settle();
        check("chain slot0 rd ready", 1, word_t'(rsp[0].rd_ready));
        check("chain slot1 rs1 ready", 0, word_t'(rsp[1].rs1_ready));
        check("chain slot1 rd ready", 0, word_t'(rsp[1].rd_ready));
        check("chain slot1 rd", 7, word_t'(rsp[1].rd));
        // release r7 for later tests
        next_cycle();
        set_wb(0, 5'd7, $urandom());
    endtask

    task automatic flush_context();
        next_cycle();
        set_slot(0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd8, 4'b0010);
        set_slot(1, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd9, 4'b0100);
        settle();
        check("flush claim r8", 1, word_t'(rsp[0].rd_ready));
        check("flush claim r9", 1, word_t'(rsp[1].rd_ready));
        next_cycle();
        branch_hazard = 1'b1;
        hazard_ctx    = 4'b0010;
        set_slot(0, 1'b1, 5'd2, 1'b1, 5'd3, 1'b1, 5'd11, 4'b0010);
        set_slot(1, 1'b1, 5'd8, 1'b1, 5'd9, 1'b0, 5'd0, 4'b0001);
        settle();
        check("flush slot0 hazard", 1, word_t'(rsp[0].hazard));
        check("flush slot0 rs1 ready", 0, word_t'(rsp[0].rs1_ready));
        check("flush slot0 rs2 ready", 0, word_t'(rsp[0].rs2_ready));
        check("flush slot0 rd ready", 0, word_t'(rsp[0].rd_ready));
        check("flush slot1 hazard", 0, word_t'(rsp[1].hazard));
        check("flush r8 ready", 1, word_t'(rsp[1].rs1_ready));
        check("flush r9 ready", 0, word_t'(rsp[1].rs2_ready));
        next_cycle();
        set_slot(0, 1'b1, 5'd9, 1'b1, 5'd8, 1'b0, 5'd0, 4'b0001);
        settle();
        check("after flush r9 ready", 0, word_t'(rsp[0].rs1_ready));
        check("after flush r8 ready", 1, word_t'(rsp[0].rs2_ready));
        next_cycle();
        set_wb(1, 5'd9, $urandom());
    endtask

    task automatic link_reg_read();
        word_t w;
        w = $urandom();
        next_cycle();
        set_wb(0, preg_addr_t'(`LR_ADDR), w);
        settle();
        check("lr same cycle", w, lr_data);
        for (int c = 0; c < 3; c++) begin
            next_cycle();
            settle();
            check("lr later cycle", w, lr_data);
        end
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        checks = 0;
        errors = 0;
        quiet_inputs();
        void'($urandom(32'h7370));
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        write_then_read();
        bypass_same_cycle();
        raw_stall();
        chain_in_bundle();
        flush_context();
        link_reg_read();
        next_cycle();
        report_and_finish();
    end

endmodule

// File: reg_stage.f
+incdir+include
src/reg_types_pkg.sv
src/inst_pkg.sv
src/reg_file.sv
src/pending_table.sv
src/reg_manage.sv
src/reg_stage.sv
tests/tb_reg_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reg_stage testbench with Verilator.
# Exits nonzero when the build, the run or the pass check fails.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing --assert \
    --top-module tb_reg_stage \
    --Mdir "$OBJ_DIR" \
    -f reg_stage.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_reg_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
